// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   localparam int data_width = 32;

   typedef logic [3:0]            reg_addr_t;
   typedef logic [data_width-1:0] word_t;

   // opcode class in ir[27:25]
   typedef enum logic [2:0] {
      cls_alu_reg = 3'd0,
      cls_alu_imm = 3'd1,
      cls_call    = 3'd2,
      cls_ext     = 3'd3,   // runs as a no-op
      cls_st_reg  = 3'd4,
      cls_ld_reg  = 3'd5,
      cls_st_imm  = 3'd6,
      cls_ld_imm  = 3'd7
   } inst_class_e;

   // codes 12..15 behave as mov
   typedef enum logic [3:0] {
      op_add = 4'd0,
      op_adc = 4'd1,
      op_sub = 4'd2,
      op_sbb = 4'd3,
      op_and = 4'd4,
      op_or  = 4'd5,
      op_xor = 4'd6,
      op_mov = 4'd7,
      op_shl = 4'd8,
      op_shr = 4'd9,
      op_cmp = 4'd10,   // sub, no writeback
      op_tst = 4'd11    // and, no writeback
   } alu_op_e;

   // codes 7..15 never execute
   typedef enum logic [3:0] {
      cond_always = 4'd0,
      cond_z      = 4'd1,
      cond_nz     = 4'd2,
      cond_c      = 4'd3,
      cond_nc     = 4'd4,
      cond_s      = 4'd5,
      cond_ns     = 4'd6
   } cond_e;

   localparam int flag_z_idx = 0;
   localparam int flag_c_idx = 1;
   localparam int flag_s_idx = 2;
   localparam int flag_v_idx = 3;

   localparam reg_addr_t pc_reg   = 4'd15;
   localparam reg_addr_t link_reg = 4'd14;

endpackage

`default_nettype wire

// ==== src/phase_sched.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_sched (
   input  wire        clk,
   input  wire        rst_n,
   output logic       phf,
   output logic       phe,
   output logic       phm,
   output logic       phw,
   output logic [1:0] phase_stat
);

   logic [3:0] ph;   // one-hot, bit 0 = fetch

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ph <= 4'b0001;
      else
         ph <= {ph[2:0], ph[3]};   // rotate fetch -> exec -> mem -> wb
   end

   assign phf = ph[0];
   assign phe = ph[1];
   assign phm = ph[2];
   assign phw = ph[3];

   // 0 fetch, 1 exec, 2 mem, 3 writeback
   assign phase_stat = {phm | phw, phe | phw};

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire cpu_pkg::reg_addr_t rd_addr,
   input  wire cpu_pkg::reg_addr_t rb_addr,
   input  wire cpu_pkg::reg_addr_t test_rsel,
   output cpu_pkg::word_t         rd_data,
   output cpu_pkg::word_t         rb_data,
   output cpu_pkg::word_t         test_reg,
   input  wire                    wen,
   input  wire cpu_pkg::reg_addr_t waddr,
   input  wire cpu_pkg::word_t    wdata,
   output cpu_pkg::word_t         pc,
   input  wire                    pc_inc
);

   cpu_pkg::word_t regs [16];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (pc_inc)
            regs[cpu_pkg::pc_reg] <= regs[cpu_pkg::pc_reg] + 1'b1;
         // later assignment wins, so a jump beats the increment
         if (wen)
            regs[waddr] <= wdata;
      end
   end

   assign rd_data  = regs[rd_addr];
   assign rb_data  = regs[rb_addr];
   assign test_reg = regs[test_rsel];   // test port, no latency
   assign pc       = regs[cpu_pkg::pc_reg];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
   input  wire cpu_pkg::alu_op_e op,
   input  wire cpu_pkg::word_t   a,
   input  wire cpu_pkg::word_t   b,
   input  wire logic [3:0]       flags_in,
   output cpu_pkg::word_t        res,
   output logic [3:0]            flags_out,
   output logic                  wb_en
);

   localparam int dw = cpu_pkg::data_width;

   logic          cin;
   logic [4:0]    sh;      // shift amount
   logic [dw:0]   sum;     // top bit is carry or borrow
   logic [dw:0]   shl_v;
   logic [dw:0]   shr_v;
   logic          c_new;
   logic          v_new;

   assign cin = flags_in[cpu_pkg::flag_c_idx];
   assign sh  = b[4:0];

   // extra bit catches the last bit shifted out, cin when sh is 0
   assign shl_v = {cin, a} << sh;
   assign shr_v = {a, cin} >> sh;

   always_comb
   begin
      sum   = '0;
      res   = b;
      c_new = cin;   // logic ops keep carry
      v_new = 1'b0;
      wb_en = 1'b1;
      case (op)
         cpu_pkg::op_add, cpu_pkg::op_adc:
         begin
            sum   = {1'b0, a} + {1'b0, b} + ((op == cpu_pkg::op_adc) ? cin : 1'b0);
            res   = sum[dw-1:0];
            c_new = sum[dw];
            v_new = (a[dw-1] == b[dw-1]) && (res[dw-1] != a[dw-1]);
         end
         cpu_pkg::op_sub, cpu_pkg::op_sbb, cpu_pkg::op_cmp:
         begin
            sum   = {1'b0, a} - {1'b0, b} - ((op == cpu_pkg::op_sbb) ? cin : 1'b0);
            res   = sum[dw-1:0];
            c_new = sum[dw];   // borrow
            v_new = (a[dw-1] != b[dw-1]) && (res[dw-1] != a[dw-1]);
            wb_en = (op != cpu_pkg::op_cmp);
         end
         cpu_pkg::op_and, cpu_pkg::op_tst:
         begin
            res   = a & b;
            wb_en = (op != cpu_pkg::op_tst);
         end
         cpu_pkg::op_or:
            res = a | b;
         cpu_pkg::op_xor:
            res = a ^ b;
         cpu_pkg::op_shl:
         begin
            res   = shl_v[dw-1:0];
            c_new = shl_v[dw];
         end
         cpu_pkg::op_shr:
         begin
            res   = shr_v[dw:1];
            c_new = shr_v[0];
         end
         default:
            res = b;   // mov and codes 12..15
      endcase

      flags_out                      = '0;
      flags_out[cpu_pkg::flag_z_idx] = (res == '0);
      flags_out[cpu_pkg::flag_c_idx] = c_new;
      flags_out[cpu_pkg::flag_s_idx] = res[dw-1];
      flags_out[cpu_pkg::flag_v_idx] = v_new;
   end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
   input  wire                     clk,
   input  wire                     rst_n,
   output cpu_pkg::word_t          mbus_addr,
   input  wire cpu_pkg::word_t     mbus_rdata,
   output cpu_pkg::word_t          mbus_wdata,
   output logic                    mbus_wen,
   input  wire cpu_pkg::reg_addr_t test_rsel,
   output cpu_pkg::word_t          test_reg,
   output cpu_pkg::word_t          pc,
   output logic [1:0]              phase_stat
);

   localparam int dw = cpu_pkg::data_width;

   logic                 phf;
   logic                 phe;
   logic                 phm;
   logic                 phw;

   cpu_pkg::word_t       ir;        // instruction register
   logic [3:0]           flags;
   cpu_pkg::word_t       ld_data;   // load latch

   cpu_pkg::cond_e       cond;
   cpu_pkg::inst_class_e cls;
   cpu_pkg::alu_op_e     alu_op;
   cpu_pkg::reg_addr_t   rd;
   cpu_pkg::reg_addr_t   rb;
   logic [15:0]          im16;
   logic [19:0]          im20;
   logic [23:0]          im24;
   logic                 call_var;

   logic                 is_alu;
   logic                 is_call;
   logic                 is_ld;
   logic                 is_st;
   logic                 ena;       // condition passed

   cpu_pkg::word_t       rd_data;
   cpu_pkg::word_t       rb_data;
   cpu_pkg::word_t       alu_b;
   cpu_pkg::word_t       alu_res;
   logic [3:0]           alu_flags;
   logic                 alu_wb_en;

   cpu_pkg::word_t       call_target;
   cpu_pkg::word_t       ldst_addr;
   logic                 inst_wb;
   logic                 wb_en;
   cpu_pkg::reg_addr_t   wb_addr;
   cpu_pkg::word_t       wb_data;

   phase_sched sched_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .phf        (phf),
      .phe        (phe),
      .phm        (phm),
      .phw        (phw),
      .phase_stat (phase_stat)
   );

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ir    <= '0;
         flags <= '0;
      end
      else
      begin
         if (phf)
            ir <= mbus_rdata;
         if (phw && ena && is_alu)   // flags only for executed ALU ops
            flags <= alu_flags;
      end
   end

   always_ff @(posedge clk)
   begin
      if (phm && is_ld)
         ld_data <= mbus_rdata;
   end

   // instruction fields
   assign cond     = cpu_pkg::cond_e'(ir[31:28]);
   assign cls      = cpu_pkg::inst_class_e'(ir[27:25]);
   assign call_var = ir[24];
   assign rd       = ir[23:20];
   assign alu_op   = cpu_pkg::alu_op_e'(ir[19:16]);
   assign rb       = ir[11:8];
   assign im16     = ir[15:0];
   assign im20     = ir[19:0];
   assign im24     = ir[23:0];

   // ext class matches none of these, so it only bumps the PC
   assign is_alu  = (cls == cpu_pkg::cls_alu_reg) || (cls == cpu_pkg::cls_alu_imm);
   assign is_call = (cls == cpu_pkg::cls_call);
   assign is_ld   = (cls == cpu_pkg::cls_ld_reg) || (cls == cpu_pkg::cls_ld_imm);
   assign is_st   = (cls == cpu_pkg::cls_st_reg) || (cls == cpu_pkg::cls_st_imm);

   always_comb
   begin
      case (cond)
         cpu_pkg::cond_always: ena = 1'b1;
         cpu_pkg::cond_z:      ena = flags[cpu_pkg::flag_z_idx];
         cpu_pkg::cond_nz:     ena = !flags[cpu_pkg::flag_z_idx];
         cpu_pkg::cond_c:      ena = flags[cpu_pkg::flag_c_idx];
         cpu_pkg::cond_nc:     ena = !flags[cpu_pkg::flag_c_idx];
         cpu_pkg::cond_s:      ena = flags[cpu_pkg::flag_s_idx];
         cpu_pkg::cond_ns:     ena = !flags[cpu_pkg::flag_s_idx];
         default:              ena = 1'b0;   // never
      endcase
   end

   reg_file rf_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr   (rd),
      .rb_addr   (rb),
      .test_rsel (test_rsel),
      .rd_data   (rd_data),
      .rb_data   (rb_data),
      .test_reg  (test_reg),
      .wen       (wb_en),
      .waddr     (wb_addr),
      .wdata     (wb_data),
      .pc        (pc),
      .pc_inc    (phe)
   );

   assign alu_b = (cls == cpu_pkg::cls_alu_imm) ? {{(dw-16){1'b0}}, im16} : rb_data;

   alu alu_i (
      .op        (alu_op),
      .a         (rd_data),
      .b         (alu_b),
      .flags_in  (flags),
      .res       (alu_res),
      .flags_out (alu_flags),
      .wb_en     (alu_wb_en)
   );

   // indexed call reads rd in phw, after the link write to r14
   assign call_target = call_var ? rd_data + {{(dw-20){im20[19]}}, im20}
                                 : {{(dw-24){1'b0}}, im24};

   assign ldst_addr = ((cls == cpu_pkg::cls_st_reg) || (cls == cpu_pkg::cls_ld_reg))
                      ? rb_data : {{(dw-16){1'b0}}, im16};

   assign inst_wb = (is_alu && alu_wb_en) || is_ld || is_call;

   // link goes to r14 in phm, the result in phw
   assign wb_en   = ena && ((phm && is_call) || (phw && inst_wb));
   assign wb_addr = phm ? cpu_pkg::link_reg
                  : (is_call ? cpu_pkg::pc_reg : rd);
   assign wb_data = phm     ? pc                  // already incremented in phe
                  : is_call ? call_target
                  : is_ld   ? ld_data
                  : alu_res;

   // bus side
   assign mbus_addr  = (phm && (is_ld || is_st)) ? ldst_addr : pc;
   assign mbus_wdata = rd_data;
   assign mbus_wen   = ena && phm && is_st;

endmodule

`default_nettype wire

// ==== src/sys_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module sys_mem #(
   parameter int MEM_WORDS = 256
) (
   input  wire                 clk,
   input  wire cpu_pkg::word_t addr,
   output cpu_pkg::word_t      rdata,
   input  wire cpu_pkg::word_t wdata,
   input  wire                 wen,
   input  wire                 load_en,
   input  wire cpu_pkg::word_t load_addr,
   input  wire cpu_pkg::word_t load_wdata,
   output cpu_pkg::word_t      load_rdata
);

   localparam int aw = $clog2(MEM_WORDS);

   cpu_pkg::word_t mem [MEM_WORDS];

   logic [aw-1:0] core_idx;   // wraps on the low bits
   logic [aw-1:0] load_idx;

   assign core_idx = addr[aw-1:0];
   assign load_idx = load_addr[aw-1:0];

   always_ff @(posedge clk)
   begin
      if (load_en)
         mem[load_idx] <= load_wdata;   // load port wins
      else if (wen)
         mem[core_idx] <= wdata;
   end

   assign rdata      = mem[core_idx];
   assign load_rdata = mem[load_idx];

endmodule

`default_nettype wire

// ==== src/cpu_sys_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_sys_top #(
   parameter int MEM_WORDS = 256
) (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     load_en,
   input  wire cpu_pkg::word_t     load_addr,
   input  wire cpu_pkg::word_t     load_wdata,
   output cpu_pkg::word_t          load_rdata,
   input  wire cpu_pkg::reg_addr_t test_rsel,
   output cpu_pkg::word_t          test_reg,
   output cpu_pkg::word_t          pc,
   output logic [1:0]              phase_stat
);

   cpu_pkg::word_t mbus_addr;
   cpu_pkg::word_t mbus_rdata;
   cpu_pkg::word_t mbus_wdata;
   logic           mbus_wen;

   cpu_core core_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .mbus_addr  (mbus_addr),
      .mbus_rdata (mbus_rdata),
      .mbus_wdata (mbus_wdata),
      .mbus_wen   (mbus_wen),
      .test_rsel  (test_rsel),
      .test_reg   (test_reg),
      .pc         (pc),
      .phase_stat (phase_stat)
   );

   sys_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) mem_i (
      .clk        (clk),
      .addr       (mbus_addr),
      .rdata      (mbus_rdata),
      .wdata      (mbus_wdata),
      .wen        (mbus_wen),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_wdata (load_wdata),
      .load_rdata (load_rdata)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_tasks.svh ====
`ifndef TB_CPU_TASKS_SVH
`define TB_CPU_TASKS_SVH

   // reg form operand, rb lives in bits 11:8
   function automatic logic [15:0] rb_field(input cpu_pkg::reg_addr_t rb);
      return {4'h0, rb, 8'h00};
   endfunction

   function automatic cpu_pkg::word_t alu_inst(input logic [3:0] cond, input logic imm,
                                               input logic [3:0] op, input cpu_pkg::reg_addr_t rd,
                                               input logic [15:0] im16);
      cpu_pkg::inst_class_e cls;
      cls = imm ? cpu_pkg::cls_alu_imm : cpu_pkg::cls_alu_reg;
      return {cond, cls, 1'b0, rd, op, im16};
   endfunction

   function automatic cpu_pkg::word_t mem_inst(input cpu_pkg::inst_class_e cls,
                                               input cpu_pkg::reg_addr_t rd,
                                               input logic [15:0] im16);
      return {4'h0, cls, 1'b0, rd, 4'h0, im16};
   endfunction

   function automatic cpu_pkg::word_t call_abs(input logic [23:0] im24);
      return {4'h0, cpu_pkg::cls_call, 1'b0, im24};
   endfunction

   function automatic cpu_pkg::word_t call_idx(input cpu_pkg::reg_addr_t rd,
                                               input logic [19:0] im20);
      return {4'h0, cpu_pkg::cls_call, 1'b1, rd, im20};
   endfunction

   function automatic cpu_pkg::word_t ext_inst(input logic [24:0] bits);
      return {4'h0, cpu_pkg::cls_ext, bits};
   endfunction

   // core held in reset while the load port writes the image
   task automatic load_program();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      foreach (prog[a])
      begin
         load_en    = 1'b1;
         load_addr  = cpu_pkg::word_t'(a);
         load_wdata = prog[a];
         @(negedge clk);
      end
      load_en = 1'b0;
   endtask

   task automatic release_reset();
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   // halt loop keeps pc on halt_at or halt_at + 1
   task automatic run_to_halt();
      int stay;
      int cycles;
      stay   = 0;
      cycles = 0;
      while (stay < 8 && cycles < halt_timeout)
      begin
         @(negedge clk);
         cycles++;
         if (pc == halt_at || pc == halt_at + 1)
            stay++;
         else
            stay = 0;
      end
      if (stay < 8)
      begin
         $display("timeout: pc never settled on the halt loop at %h within %0d cycles",
                  halt_at, cycles);
         errors++;
      end
   endtask

   task automatic peek_mem(input cpu_pkg::word_t addr, output cpu_pkg::word_t v);
      @(negedge clk);
      load_addr = addr;
      #1 v = load_rdata;
   endtask

   task automatic check_word(input string name, input cpu_pkg::word_t act,
                             input cpu_pkg::word_t exp);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s: got %h expected %h", name, act, exp);
         errors++;
      end
   endtask

   task automatic check_flags(input string name, input logic [3:0] act, input logic [3:0] exp);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s: got %h expected %h", name, act, exp);
         errors++;
      end
   endtask

   task automatic check_phase(input string name, input logic [1:0] act, input logic [1:0] exp);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s: got %h expected %h", name, act, exp);
         errors++;
      end
   endtask

`endif

// ==== testbench/tb_cpu_sys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_sys;

   localparam int mem_words    = 256;
   localparam int halt_timeout = 2000;   // cycles

   logic               clk;
   logic               rst_n;
   logic               load_en;
   cpu_pkg::word_t     load_addr;
   cpu_pkg::word_t     load_wdata;
   cpu_pkg::word_t     load_rdata;
   cpu_pkg::reg_addr_t test_rsel;
   cpu_pkg::word_t     test_reg;
   cpu_pkg::word_t     pc;
   logic [1:0]         phase_stat;

   cpu_pkg::word_t     prog [int];   // address -> instruction
   int                 wp;           // next free program address
   cpu_pkg::word_t     halt_at;
   cpu_pkg::word_t     mreg [16];    // expected register contents
   logic [3:0]         mflags;       // expected flags
   logic [31:0]        lfsr;
   int                 errors;
   int                 tests_passed;
   int                 tests_failed;

   cpu_sys_top #(
      .MEM_WORDS (mem_words)
   ) dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_wdata (load_wdata),
      .load_rdata (load_rdata),
      .test_rsel  (test_rsel),
      .test_reg   (test_reg),
      .pc         (pc),
      .phase_stat (phase_stat)
   );

   `include "tb_cpu_tasks.svh"

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // right-shift Galois LFSR, taps 32 30 26 25
   function automatic cpu_pkg::word_t rand_bits(input int n);
      cpu_pkg::word_t v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic cond_pass(input logic [3:0] cond, input logic [3:0] f);
      case (cond)
         4'd0:    return 1'b1;
         4'd1:    return f[cpu_pkg::flag_z_idx];
         4'd2:    return !f[cpu_pkg::flag_z_idx];
         4'd3:    return f[cpu_pkg::flag_c_idx];
         4'd4:    return !f[cpu_pkg::flag_c_idx];
         4'd5:    return f[cpu_pkg::flag_s_idx];
         4'd6:    return !f[cpu_pkg::flag_s_idx];
         default: return 1'b0;
      endcase
   endfunction

   // expected result of one ALU operation
   task automatic alu_ref(input logic [3:0] op, input cpu_pkg::word_t a, input cpu_pkg::word_t b,
                          input logic [3:0] fin, output cpu_pkg::word_t res,
                          output logic [3:0] fout, output logic wb);
      logic [32:0] wide;
      int          n;
      logic        c;
      logic        v;
      c  = fin[cpu_pkg::flag_c_idx];
      v  = 1'b0;
      wb = 1'b1;
      n  = int'(b[4:0]);
      case (op)
         4'd0, 4'd1:
         begin
            wide = 33'(a) + 33'(b) + 33'((op == 4'd1) & c);
            res  = wide[31:0];
            c    = wide[32];
            v    = (a[31] == b[31]) && (res[31] != a[31]);
         end
         4'd2, 4'd3, 4'd10:
         begin
            wide = 33'(b) + 33'((op == 4'd3) & c);   // amount taken away
            res  = a - wide[31:0];
            c    = (33'(a) < wide);                  // borrow
            v    = (a[31] != b[31]) && (res[31] != a[31]);
            wb   = (op != 4'd10);
         end
         4'd4, 4'd11:
         begin
            res = a & b;
            wb  = (op != 4'd11);
         end
         4'd5: res = a | b;
         4'd6: res = a ^ b;
         4'd8:
         begin
            res = a << n;
            if (n != 0)
               c = a[32-n];   // last bit out
         end
         4'd9:
         begin
            res = a >> n;
            if (n != 0)
               c = a[n-1];
         end
         default: res = b;
      endcase
      fout                      = '0;
      fout[cpu_pkg::flag_z_idx] = (res == '0);
      fout[cpu_pkg::flag_c_idx] = c;
      fout[cpu_pkg::flag_s_idx] = res[31];
      fout[cpu_pkg::flag_v_idx] = v;
   endtask

   task automatic put(input cpu_pkg::word_t inst);
      prog[wp] = inst;
      wp++;
   endtask

   // appends an ALU instruction and applies it to the model
   task automatic alu_emit(input logic [3:0] cond, input logic imm, input logic [3:0] op,
                           input cpu_pkg::reg_addr_t rd, input logic [15:0] src);
      cpu_pkg::word_t b;
      cpu_pkg::word_t res;
      logic [3:0]     fout;
      logic           wb;
      b = imm ? {16'h0, src} : mreg[src[11:8]];
      alu_ref(op, mreg[rd], b, mflags, res, fout, wb);
      if (cond_pass(cond, mflags))
      begin
         if (wb)
            mreg[rd] = res;
         mflags = fout;
      end
      put(alu_inst(cond, imm, op, rd, src));
   endtask

   task automatic load_const(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t val);
      alu_emit(4'd0, 1'b1, 4'd7, rd, val[31:16]);
      alu_emit(4'd0, 1'b1, 4'd8, rd, 16'd16);
      alu_emit(4'd0, 1'b1, 4'd5, rd, val[15:0]);
   endtask

   task automatic emit_halt();
      halt_at = cpu_pkg::word_t'(wp);
      put(alu_inst(4'd0, 1'b1, 4'd7, cpu_pkg::pc_reg, 16'(wp)));   // mov r15 to itself
   endtask

   task automatic new_program();
      prog.delete();
      wp = 0;
      for (int i = 0; i < 16; i++)
         mreg[i] = '0;
      mflags = '0;
   endtask

   task automatic run_program();
      load_program();
      release_reset();
      run_to_halt();
   endtask

   task automatic read_reg(input cpu_pkg::reg_addr_t r, output cpu_pkg::word_t v);
      @(negedge clk);
      test_rsel = r;
      #1 v = test_reg;
   endtask

   task automatic expect_reg(input cpu_pkg::reg_addr_t r);
      cpu_pkg::word_t v;
      read_reg(r, v);
      check_word($sformatf("r%0d", r), v, mreg[r]);
   endtask

   task automatic finish_test(input string name, input int err0);
      if (errors == err0)
      begin
         tests_passed++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d check(s) wrong", name, errors - err0);
      end
   endtask

   task automatic reset_and_phases();
      int err0;
      err0 = errors;
      new_program();
      alu_emit(4'd0, 1'b1, 4'd7, 4'd1, 16'(rand_bits(16)));
      put(ext_inst(25'(rand_bits(25))));   // must act as a no-op
      emit_halt();
      load_program();
      release_reset();
      #1;
      check_word("pc", pc, '0);
      check_phase("phase_stat", phase_stat, 2'd0);
      for (int i = 1; i <= 4; i++)
      begin
         @(negedge clk);
         #1 check_phase("phase_stat", phase_stat, 2'(i));
      end
      run_to_halt();
      for (int i = 0; i < 15; i++)
         expect_reg(4'(i));
      finish_test("reset and phase sequence", err0);
   endtask

   task automatic alu_forms();
      int             err0;
      cpu_pkg::word_t va;
      cpu_pkg::word_t vb;
      logic [15:0]    vi;
      err0 = errors;
      for (int op = 0; op < 12; op++)
      begin
         va = rand_bits(32);
         vb = rand_bits(32);
         vi = 16'(rand_bits(16));
         new_program();
         load_const(4'd1, va);
         load_const(4'd2, vb);
         alu_emit(4'd0, 1'b0, 4'd7, 4'd3, rb_field(4'd1));
         alu_emit(4'd0, 1'b0, 4'(op), 4'd3, rb_field(4'd2));
         alu_emit(4'd0, 1'b0, 4'd7, 4'd4, rb_field(4'd1));
         alu_emit(4'd0, 1'b1, 4'(op), 4'd4, vi);
         emit_halt();
         run_program();
         expect_reg(4'd3);   // cmp and tst leave the copy of r1
         expect_reg(4'd4);
      end
      finish_test("alu register and immediate forms", err0);
   endtask

   task automatic cond_codes();
      int             err0;
      cpu_pkg::word_t va;
      cpu_pkg::word_t vb;
      cpu_pkg::word_t mask;
      logic [3:0]     f_cmp;
      logic [3:0]     f_seen;
      err0 = errors;
      for (int round = 0; round < 4; round++)
      begin
         va = rand_bits(32);
         vb = (round == 0) ? va : rand_bits(32);
         new_program();
         load_const(4'd1, va);
         load_const(4'd2, vb);
         // one mask bit per condition code, fresh cmp before each
         for (int c = 0; c < 16; c++)
         begin
            alu_emit(4'd0, 1'b0, 4'd10, 4'd1, rb_field(4'd2));
            f_cmp = mflags;
            alu_emit(4'(c), 1'b1, 4'd5, 4'd3, 16'(1 << c));
         end
         emit_halt();
         run_program();
         expect_reg(4'd3);
         read_reg(4'd3, mask);
         f_seen                           = '0;
         f_seen[cpu_pkg::flag_z_idx]      = mask[1];
         f_seen[cpu_pkg::flag_c_idx]      = mask[3];
         f_seen[cpu_pkg::flag_s_idx]      = mask[5];
         f_cmp[cpu_pkg::flag_v_idx]       = 1'b0;   // no condition reads V
         check_flags("flags after cmp", f_seen, f_cmp);
      end
      finish_test("flags and conditions", err0);
   endtask

   task automatic load_store();
      int             err0;
      cpu_pkg::word_t va;
      cpu_pkg::word_t vb;
      cpu_pkg::word_t v;
      logic [15:0]    aimm;
      logic [15:0]    areg;
      err0 = errors;
      for (int round = 0; round < 2; round++)
      begin
         va   = rand_bits(32);
         vb   = rand_bits(32);
         aimm = 16'h0080 | 16'(rand_bits(4));
         areg = 16'h00c0 | 16'(rand_bits(4));
         new_program();
         load_const(4'd1, va);
         load_const(4'd2, vb);
         alu_emit(4'd0, 1'b1, 4'd7, 4'd5, areg);
         put(mem_inst(cpu_pkg::cls_st_imm, 4'd1, aimm));
         put(mem_inst(cpu_pkg::cls_st_reg, 4'd2, rb_field(4'd5)));
         put(mem_inst(cpu_pkg::cls_ld_imm, 4'd6, aimm));
         put(mem_inst(cpu_pkg::cls_ld_reg, 4'd7, rb_field(4'd5)));
         mreg[6] = va;
         mreg[7] = vb;
         emit_halt();
         run_program();
         expect_reg(4'd6);
         expect_reg(4'd7);
         @(negedge clk);
         rst_n = 1'b0;   // park the core before using the load port
         peek_mem({16'h0, aimm}, v);
         check_word($sformatf("mem[%h]", aimm), v, va);
         peek_mem({16'h0, areg}, v);
         check_word($sformatf("mem[%h]", areg), v, vb);
      end
      finish_test("load and store", err0);
   endtask

   task automatic calls_and_jumps();
      int             err0;
      logic [3:0]     off4;
      cpu_pkg::word_t base;
      err0 = errors;
      off4 = 4'(rand_bits(4));
      base = 32'h30 - {{28{off4[3]}}, off4};   // indexed call lands on 0x30
      new_program();
      put(alu_inst(4'd0, 1'b1, 4'd7, 4'd2, base[15:0]));
      put(call_abs(24'h20));
      put(alu_inst(4'd0, 1'b1, 4'd7, 4'd9, 16'h0bad));      // never reached
      wp = 32'h20;
      put(alu_inst(4'd0, 1'b0, 4'd7, 4'd1, rb_field(4'd14)));
      put(call_idx(4'd2, {{16{off4[3]}}, off4}));
      wp = 32'h30;
      put(alu_inst(4'd0, 1'b0, 4'd7, 4'd3, rb_field(4'd14)));
      put(alu_inst(4'd0, 1'b1, 4'd7, cpu_pkg::pc_reg, 16'h0038));
      put(alu_inst(4'd0, 1'b1, 4'd7, 4'd9, 16'h0bad));      // jumped over
      wp = 32'h38;
      put(alu_inst(4'd0, 1'b1, 4'd7, 4'd4, 16'h5a5a));
      emit_halt();
      mreg[1]  = 32'h2;    // link of the absolute call
      mreg[2]  = base;
      mreg[3]  = 32'h22;   // link of the indexed call
      mreg[4]  = 32'h5a5a;
      mreg[14] = 32'h22;
      run_program();
      expect_reg(4'd1);
      expect_reg(4'd2);
      expect_reg(4'd3);
      expect_reg(4'd4);
      expect_reg(4'd9);
      expect_reg(4'd14);
      finish_test("calls and jumps", err0);
   endtask

   initial
   begin
      rst_n        = 1'b0;
      load_en      = 1'b0;
      load_addr    = '0;
      load_wdata   = '0;
      test_rsel    = '0;
      lfsr         = 32'h858c2bbc;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (2) @(negedge clk);

      reset_and_phases();
      alu_forms();
      cond_codes();
      load_store();
      calls_and_jumps();

      $display("tests passed: %0d, tests failed: %0d, wrong checks: %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+testbench
src/cpu_pkg.sv
src/phase_sched.sv
src/reg_file.sv
src/alu.sv
src/cpu_core.sv
src/sys_mem.sv
src/cpu_sys_top.sv
testbench/tb_cpu_sys.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
TOP        := tb_cpu_sys
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
